// File: verilog/char_edit_pkg.sv
// Character editor widths, display types, glyph constants and debouncer states
package char_edit_pkg;

    // Display geometry
    localparam int NUM_DIGITS = 7;

    // Digit number, used for both the cursor and the scan position
    typedef logic [2:0] digit_sel_t;

    // Character code, 0 to MAX_CODE
    typedef logic [6:0] char_code_t;

    // Active low segment pattern, bit order g down to a
    typedef logic [6:0] segments_t;

    // Active low, one bit per digit
    typedef logic [NUM_DIGITS-1:0] digit_mask_t;

    localparam digit_sel_t LAST_DIGIT = digit_sel_t'(NUM_DIGITS - 1);

    // Stepping past this wraps to 0
    localparam char_code_t MAX_CODE = 7'd62;

    localparam segments_t SEG_BLANK = 7'b111_1111;

    // Lone middle bar for codes without a digit glyph
    localparam segments_t SEG_UNKNOWN = 7'b011_1111;

    localparam segments_t DIGIT_GLYPHS [10] = '{
        7'b100_0000,  // 0
        7'b111_1001,  // 1
        7'b010_0100,  // 2
        7'b011_0000,  // 3
        7'b001_1001,  // 4
        7'b001_0010,  // 5
        7'b000_0010,  // 6
        7'b111_1000,  // 7
        7'b000_0000,  // 8
        7'b001_0000   // 9
    };

    // Button debouncer FSM
    typedef enum logic [1:0] {
        DB_IDLE,
        DB_COUNT,
        DB_HELD
    } debounce_state_t;

endpackage

// File: verilog/button_pulse.sv
// Button debouncer with a two-flop synchronizer and a one-pulse-per-press output
module button_pulse
    import char_edit_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 1000000
) (
    input  logic clk,
    input  logic reset,
    input  logic btn,
    output logic step
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic btn_meta;
    logic btn_sync;
    logic [CNT_W-1:0] high_cnt;
    debounce_state_t state;

    // Raw button is asynchronous to clk
    always_ff @(posedge clk) begin
        if (reset) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= DB_IDLE;
            high_cnt <= '0;
            step     <= 1'b0;
        end else begin
            step <= 1'b0;
            case (state)
                DB_IDLE, DB_COUNT: begin
                    if (!btn_sync) begin
                        // Any low sample restarts the count
                        state    <= DB_IDLE;
                        high_cnt <= '0;
                    end else if (high_cnt == CNT_LAST) begin
                        state    <= DB_HELD;
                        high_cnt <= '0;
                        step     <= 1'b1;
                    end else begin
                        state    <= DB_COUNT;
                        high_cnt <= high_cnt + 1'b1;
                    end
                end
                // One press gives one step, wait for release
                DB_HELD: begin
                    if (!btn_sync) begin
                        state <= DB_IDLE;
                    end
                end
                default: state <= DB_IDLE;
            endcase
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (reset) step |=> !step);

endmodule

// File: verilog/glyph_rom.sv
// Character code to active-low seven-segment pattern lookup
module glyph_rom
    import char_edit_pkg::*;
(
    input  char_code_t code,
    output segments_t  glyph
);

    localparam int NUM_GLYPHS = $size(DIGIT_GLYPHS);

    logic is_digit;

    assign is_digit = (code < char_code_t'(NUM_GLYPHS));

    // Only the decimal digits have their own glyphs
    always_comb begin
        if (is_digit) begin
            glyph = DIGIT_GLYPHS[code[3:0]];
        end else begin
            glyph = SEG_UNKNOWN;
        end
    end

endmodule

// File: verilog/scan_timer.sv
// Digit scan divider and blink phase divider, both gated by mode
module scan_timer
    import char_edit_pkg::*;
#(
    parameter int SCAN_DIV  = 25000,
    parameter int BLINK_DIV = 12500000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       mode,
    output digit_sel_t scan_digit,
    output logic       blink_off
);

    localparam int SCAN_W  = $clog2(SCAN_DIV + 1);
    localparam int BLINK_W = $clog2(BLINK_DIV + 1);
    localparam logic [SCAN_W-1:0]  SCAN_LAST  = SCAN_W'(SCAN_DIV - 1);
    localparam logic [BLINK_W-1:0] BLINK_LAST = BLINK_W'(BLINK_DIV - 1);

    logic [SCAN_W-1:0]  scan_cnt;
    logic [BLINK_W-1:0] blink_cnt;

    // One digit slot every SCAN_DIV cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt   <= '0;
            scan_digit <= '0;
        end else if (!mode) begin
            scan_cnt <= '0;
        end else if (scan_cnt == SCAN_LAST) begin
            scan_cnt <= '0;
            if (scan_digit == LAST_DIGIT) begin
                scan_digit <= '0;
            end else begin
                scan_digit <= scan_digit + 3'd1;
            end
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // Blink half period
    always_ff @(posedge clk) begin
        if (reset) begin
            blink_cnt <= '0;
            blink_off <= 1'b0;
        end else if (!mode) begin
            blink_cnt <= '0;
        end else if (blink_cnt == BLINK_LAST) begin
            blink_cnt <= '0;
            blink_off <= ~blink_off;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    a_scan_range: assert property (
        @(posedge clk) disable iff (reset) scan_digit < NUM_DIGITS
    );

endmodule

// File: verilog/char_edit_regs.sv
// Cursor and character code registers stepped by the debounced button pulses
module char_edit_regs
    import char_edit_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       mode,
    input  logic       left_step,
    input  logic       right_step,
    input  logic       change_step,
    output digit_sel_t cursor,
    output char_code_t codes [NUM_DIGITS],
    output char_code_t cursor_code
);

    char_code_t next_code;

    assign cursor_code = codes[cursor];

    // Code under the cursor after one change step
    assign next_code = (cursor_code == MAX_CODE) ? '0 : cursor_code + 7'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            cursor <= '0;
        end else if (!mode) begin
            // Leaving edit mode parks the cursor on digit 0
            cursor <= '0;
        end else if (right_step) begin
            // Right has priority over left
            if (cursor == LAST_DIGIT) begin
                cursor <= '0;
            end else begin
                cursor <= cursor + 3'd1;
            end
        end else if (left_step) begin
            if (cursor == '0) begin
                cursor <= LAST_DIGIT;
            end else begin
                cursor <= cursor - 3'd1;
            end
        end
    end

    // Codes hold their values while mode is low
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                codes[i] <= '0;
            end
        end else if (mode && change_step) begin
            // Uses the cursor from before any move in this cycle
            codes[cursor] <= next_code;
        end
    end

    a_cursor_range: assert property (
        @(posedge clk) disable iff (reset) cursor < NUM_DIGITS
    );

    for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_code_chk
        a_code_range: assert property (
            @(posedge clk) disable iff (reset) codes[i] <= MAX_CODE
        );
    end

endmodule

// File: verilog/display_mux.sv
// Scan multiplexer with cursor blink blanking and registered display outputs
module display_mux
    import char_edit_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  char_code_t  codes [NUM_DIGITS],
    input  digit_sel_t  cursor,
    input  digit_sel_t  scan_digit,
    input  logic        blink_off,
    input  segments_t   glyph,
    output char_code_t  scan_code,
    output digit_mask_t digit_en,
    output segments_t   seg,
    output digit_mask_t single_led
);

    digit_mask_t digit_en_next;
    digit_mask_t single_led_next;
    segments_t   seg_next;
    logic        blank_cursor;

    // Code of the digit being scanned, sent out to the glyph lookup
    assign scan_code = codes[scan_digit];

    // Scan position 0 drives the leftmost digit, the MSB of the mask
    assign digit_en_next = ~(digit_mask_t'(1) << (LAST_DIGIT - scan_digit));

    // Cursor digit goes dark in the off phase of the blink
    assign blank_cursor = blink_off && (scan_digit == cursor);
    assign seg_next = blank_cursor ? SEG_BLANK : glyph;

    assign single_led_next = blink_off ? '1 : ~(digit_mask_t'(1) << cursor);

    always_ff @(posedge clk) begin
        if (reset) begin
            // All active-low outputs inactive
            digit_en   <= '1;
            seg        <= SEG_BLANK;
            single_led <= '1;
        end else begin
            digit_en   <= digit_en_next;
            seg        <= seg_next;
            single_led <= single_led_next;
        end
    end

    // Exactly one digit is driven once the first update has happened
    a_one_digit: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> $onehot(~digit_en)
    );

endmodule

// File: verilog/char_edit_top.sv
// Seven-digit character editor top level with debouncers, registers, scan and glyph lookup
module char_edit_top
    import char_edit_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 1000000,
    parameter int SCAN_DIV        = 25000,
    parameter int BLINK_DIV       = 12500000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        left_btn,
    input  logic        right_btn,
    input  logic        change_btn,
    input  logic        mode,
    output digit_mask_t digit_en,
    output segments_t   seg,
    output digit_mask_t single_led,
    output digit_sel_t  cursor,
    output char_code_t  cursor_code
);

    logic       left_step;
    logic       right_step;
    logic       change_step;
    char_code_t codes [NUM_DIGITS];
    digit_sel_t scan_digit;
    logic       blink_off;
    char_code_t scan_code;
    segments_t  glyph;

    // Button inputs
    button_pulse #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_left (
        .clk   (clk),
        .reset (reset),
        .btn   (left_btn),
        .step  (left_step)
    );

    button_pulse #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_right (
        .clk   (clk),
        .reset (reset),
        .btn   (right_btn),
        .step  (right_step)
    );

    button_pulse #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_change (
        .clk   (clk),
        .reset (reset),
        .btn   (change_btn),
        .step  (change_step)
    );

    char_edit_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .mode        (mode),
        .left_step   (left_step),
        .right_step  (right_step),
        .change_step (change_step),
        .cursor      (cursor),
        .codes       (codes),
        .cursor_code (cursor_code)
    );

    scan_timer #(.SCAN_DIV(SCAN_DIV), .BLINK_DIV(BLINK_DIV)) u_scan (
        .clk        (clk),
        .reset      (reset),
        .mode       (mode),
        .scan_digit (scan_digit),
        .blink_off  (blink_off)
    );

    // Single shared lookup behind the scan mux
    display_mux u_mux (
        .clk        (clk),
        .reset      (reset),
        .codes      (codes),
        .cursor     (cursor),
        .scan_digit (scan_digit),
        .blink_off  (blink_off),
        .glyph      (glyph),
        .scan_code  (scan_code),
        .digit_en   (digit_en),
        .seg        (seg),
        .single_led (single_led)
    );

    glyph_rom u_rom (
        .code  (scan_code),
        .glyph (glyph)
    );

endmodule

// File: tb/char_edit_model.svh
// Reference model of debouncers, cursor, codes, scan position, blink phase and display outputs

// Button index 0 is left, 1 is right, 2 is change
logic [2:0] ref_sync1;
logic [2:0] ref_sync2;
logic [2:0] ref_step;
int         ref_count [3];
bit         ref_held [3];

logic [2:0] ref_cursor;
logic [6:0] ref_codes [7];
int         ref_scan_cnt;
logic [2:0] ref_scan_digit;
int         ref_blink_cnt;
logic       ref_blink_off;

logic [6:0] ref_digit_en;
logic [6:0] ref_seg;
logic [6:0] ref_single_led;

// Active-low patterns in bit order g down to a
function automatic logic [6:0] expected_glyph(input logic [6:0] code);
    case (code)
        7'd0: return 7'h40;
        7'd1: return 7'h79;
        7'd2: return 7'h24;
        7'd3: return 7'h30;
        7'd4: return 7'h19;
        7'd5: return 7'h12;
        7'd6: return 7'h02;
        7'd7: return 7'h78;
        7'd8: return 7'h00;
        7'd9: return 7'h10;
        // Middle bar only
        default: return 7'h3f;
    endcase
endfunction

task automatic reset_model();
    ref_sync1 = '0;
    ref_sync2 = '0;
    ref_step = '0;
    for (int i = 0; i < 3; i++) begin
        ref_count[i] = 0;
        ref_held[i] = 0;
    end
    ref_cursor = '0;
    for (int i = 0; i < 7; i++) begin
        ref_codes[i] = '0;
    end
    ref_scan_cnt = 0;
    ref_scan_digit = '0;
    ref_blink_cnt = 0;
    ref_blink_off = 1'b0;
    ref_digit_en = 7'h7f;
    ref_seg = 7'h7f;
    ref_single_led = 7'h7f;
endtask

// One clock edge with every register computed from the state before the edge
task automatic advance_model(input logic [2:0] btns, input logic mode_in);
    logic [2:0] old_cursor;
    logic [6:0] scan_code;
    old_cursor = ref_cursor;
    scan_code = ref_codes[ref_scan_digit];

    ref_digit_en = 7'h7f ^ (7'h01 << (6 - ref_scan_digit));
    if (ref_blink_off && (ref_scan_digit == ref_cursor)) begin
        ref_seg = 7'h7f;
    end else begin
        ref_seg = expected_glyph(scan_code);
    end
    ref_single_led = ref_blink_off ? 7'h7f : (7'h7f ^ (7'h01 << ref_cursor));

    // Pulses from the previous edge act now
    if (mode_in && ref_step[2]) begin
        if (ref_codes[old_cursor] == 7'd62) begin
            ref_codes[old_cursor] = 7'd0;
        end else begin
            ref_codes[old_cursor] = ref_codes[old_cursor] + 7'd1;
        end
    end
    if (!mode_in) begin
        ref_cursor = '0;
    end else if (ref_step[1]) begin
        ref_cursor = (old_cursor == 3'd6) ? 3'd0 : old_cursor + 3'd1;
    end else if (ref_step[0]) begin
        ref_cursor = (old_cursor == 3'd0) ? 3'd6 : old_cursor - 3'd1;
    end

    for (int i = 0; i < 3; i++) begin
        ref_step[i] = 1'b0;
        if (ref_held[i]) begin
            ref_held[i] = ref_sync2[i];
        end else if (!ref_sync2[i]) begin
            ref_count[i] = 0;
        end else begin
            ref_count[i]++;
            if (ref_count[i] == DEBOUNCE_CYCLES) begin
                ref_step[i] = 1'b1;
                ref_held[i] = 1;
                ref_count[i] = 0;
            end
        end
    end
    ref_sync2 = ref_sync1;
    ref_sync1 = btns;

    if (!mode_in) begin
        ref_scan_cnt = 0;
        ref_blink_cnt = 0;
    end else begin
        if (ref_scan_cnt == SCAN_DIV - 1) begin
            ref_scan_cnt = 0;
            ref_scan_digit = (ref_scan_digit == 3'd6) ? 3'd0 : ref_scan_digit + 3'd1;
        end else begin
            ref_scan_cnt++;
        end
        if (ref_blink_cnt == BLINK_DIV - 1) begin
            ref_blink_cnt = 0;
            ref_blink_off = ~ref_blink_off;
        end else begin
            ref_blink_cnt++;
        end
    end
endtask

// File: tb/char_edit_tb.sv
// Testbench for the character editor with seeded random buttons, mode drops and a reference model
module char_edit_tb;

    localparam int DEBOUNCE_CYCLES  = 3;
    localparam int SCAN_DIV         = 4;
    localparam int BLINK_DIV        = 40;
    localparam int CLK_PERIOD       = 20;
    localparam int RESET_CYCLES     = 5;
    localparam int DIRECTED_PRESSES = 64;
    localparam int DIRECTED_CYCLES  = DIRECTED_PRESSES * 9;
    localparam int RANDOM_CYCLES    = 4000;
    localparam int TOTAL_CYCLES     = RESET_CYCLES + 1 + DIRECTED_CYCLES + RANDOM_CYCLES;
    localparam int TIMEOUT_CYCLES   = TOTAL_CYCLES + 200;

    logic       clk;
    logic       reset;
    logic       left_btn;
    logic       right_btn;
    logic       change_btn;
    logic       mode;
    logic [6:0] digit_en;
    logic [6:0] seg;
    logic [6:0] single_led;
    logic [2:0] cursor;
    logic [6:0] cursor_code;

    int         seed = 89;
    int         error_count = 0;
    int         hold_left = 0;
    int         gap_left = 0;
    int         mode_low_left = 0;
    logic [2:0] next_btns = 3'b000;
    logic       next_mode = 1'b1;

    `include "char_edit_model.svh"

    char_edit_top #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .SCAN_DIV        (SCAN_DIV),
        .BLINK_DIV       (BLINK_DIV)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .left_btn    (left_btn),
        .right_btn   (right_btn),
        .change_btn  (change_btn),
        .mode        (mode),
        .digit_en    (digit_en),
        .seg         (seg),
        .single_led  (single_led),
        .cursor      (cursor),
        .cursor_code (cursor_code)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [6:0] expected,
                               input logic [6:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_outputs();
        check_value("cursor", {4'b0, ref_cursor}, {4'b0, cursor});
        check_value("cursor_code", ref_codes[ref_cursor], cursor_code);
        check_value("digit_en", ref_digit_en, digit_en);
        check_value("seg", ref_seg, seg);
        check_value("single_led", ref_single_led, single_led);
    endtask

    // Model sees the inputs the DUT samples at this edge, new inputs follow
    task automatic run_cycle(input logic [2:0] btns, input logic mode_val);
        @(posedge clk);
        advance_model({change_btn, right_btn, left_btn}, mode);
        {change_btn, right_btn, left_btn} <= btns;
        mode <= mode_val;
        @(negedge clk);
        check_outputs();
    endtask

    // Presses of 1 to 8 cycles with low gaps, now and then a mode drop
    task automatic pick_stimulus();
        int pick;
        if (mode_low_left > 0) begin
            mode_low_left--;
            next_mode = (mode_low_left == 0);
        end
        if (hold_left > 0) begin
            hold_left--;
        end else if (gap_left > 0) begin
            next_btns = 3'b000;
            gap_left--;
        end else begin
            pick = {$random(seed)} % 16;
            if (pick < 4) begin
                next_btns = 3'b001;
            end else if (pick < 8) begin
                next_btns = 3'b010;
            end else if (pick < 13) begin
                next_btns = 3'b100;
            end else if (pick < 15) begin
                // Left and right together
                next_btns = 3'b011;
            end else begin
                next_btns = 3'b000;
                if (mode_low_left == 0) begin
                    next_mode = 1'b0;
                    mode_low_left = 5 + {$random(seed)} % 20;
                end
            end
            hold_left = {$random(seed)} % 8;
            gap_left = 1 + {$random(seed)} % 6;
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, stimulus did not complete", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        reset = 1'b1;
        left_btn = 1'b0;
        right_btn = 1'b0;
        change_btn = 1'b0;
        mode = 1'b1;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_outputs();

        // Enough change presses on digit 0 to wrap its code past 62
        for (int p = 0; p < DIRECTED_PRESSES; p++) begin
            repeat (5) run_cycle(3'b100, 1'b1);
            repeat (4) run_cycle(3'b000, 1'b1);
        end

        repeat (RANDOM_CYCLES) begin
            pick_stimulus();
            run_cycle(next_btns, next_mode);
        end

        $display("Checks done after %0d cycles with %0d errors", TOTAL_CYCLES, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+tb
verilog/char_edit_pkg.sv
verilog/button_pulse.sv
verilog/glyph_rom.sv
verilog/scan_timer.sv
verilog/char_edit_regs.sv
verilog/display_mux.sv
verilog/char_edit_top.sv
tb/char_edit_tb.sv
